// ==== design/i2s_macros.svh ====
/*
 * I2S master parameters
 * Clock divider, sample and FIFO sizes, APB register offsets
 * and the bit positions of the command register.
 */
`ifndef I2S_MACROS_SVH
`define I2S_MACROS_SVH

// clk cycles per sclk half period
`define I2S_SCLK_DIV 2
`define I2S_SAMPLE_W 16
`define I2S_FIFO_DEPTH 8
`define I2S_FIFO_LEVEL_W 4

// APB bus widths
`define I2S_ADDR_W 8
`define I2S_APB_DATA_W 32

// Register map
`define I2S_REG_CMD 8'h00
`define I2S_REG_STATUS 8'h04
`define I2S_REG_TX_DATA 8'h08
`define I2S_REG_RX_DATA 8'h0C
`define I2S_REG_IRQ_LEVEL 8'h10

// Command register bits
`define I2S_CMD_TX_START 0
`define I2S_CMD_TX_STOP 1
`define I2S_CMD_RX_ENABLE 2
`define I2S_CMD_RX_DISABLE 3
`define I2S_CMD_IRQ_CLEAR 4
`define I2S_CMD_FLAG_CLEAR 5

`endif

// ==== design/i2s_reg_pkg.sv ====
/*
 * I2S register-side types
 * Command strobes, FIFO status, control status and the
 * transmit state encoding.
 */
`include "i2s_macros.svh"

package i2s_reg_pkg;

	typedef logic [`I2S_FIFO_LEVEL_W-1:0] level_t;

	// One-cycle strobes, declared from bit 5 down to bit 0
	typedef struct packed
	{
		logic flag_clear;
		logic irq_clear;
		logic rx_disable;
		logic rx_enable;
		logic tx_stop;
		logic tx_start;
	} i2s_cmd_t;

	typedef struct packed
	{
		level_t level;
		logic empty;
		logic full;
	} fifo_stat_t;

	typedef enum logic [1:0]
	{
		TX_IDLE,
		TX_PREFILL,
		TX_RUN
	} tx_state_t;

	// tx_running lands in bit 0 of the STATUS word
	typedef struct packed
	{
		logic rx_overflow;
		logic tx_underflow;
		logic irq;
		logic rx_enabled;
		logic tx_running;
	} i2s_status_t;

endpackage

// ==== design/i2s_audio_pkg.sv ====
/*
 * I2S audio types
 * One channel sample and one stereo frame, left sample
 * in the upper half of the frame.
 */
`include "i2s_macros.svh"

package i2s_audio_pkg;

	typedef logic [`I2S_SAMPLE_W-1:0] sample_t;

	// Left channel in the upper half, right channel in the lower half
	typedef logic [2*$bits(sample_t)-1:0] frame_t;

endpackage

// ==== design/i2s_apb_regs.sv ====
/*
 * I2S APB register block
 * Decodes the register map, turns CMD writes into strobes,
 * pushes transmit frames, pops receive frames and holds the
 * interrupt threshold. No wait states.
 */
`timescale 1ns/100ps
`include "i2s_macros.svh"

module i2s_apb_regs
	import i2s_reg_pkg::*, i2s_audio_pkg::*;
(
	input logic clk,
	input logic rstnn,
	input logic psel,
	input logic penable,
	input logic [`I2S_ADDR_W-1:0] paddr,
	input logic pwrite,
	input logic [`I2S_APB_DATA_W-1:0] pwdata,
	output logic [`I2S_APB_DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input i2s_status_t status,
	input fifo_stat_t tx_stat,
	input fifo_stat_t rx_stat,
	input frame_t rx_rdata,
	output i2s_cmd_t cmd,
	output level_t irq_level,
	output logic tx_push,
	output frame_t tx_wdata,
	output logic rx_pop
);

	logic access;
	logic [`I2S_APB_DATA_W-1:0] status_word;

	assign access = psel & penable;
	assign pready = 1'b1;
	assign tx_wdata = pwdata;

	// STATUS: control flags, then tx level, then rx level
	assign status_word = `I2S_APB_DATA_W'({rx_stat.level, tx_stat.level, status});

	// **************************************************
	// Access decode
	// **************************************************
	always_comb
	begin
		prdata = '0;
		pslverr = 1'b0;
		cmd = '0;
		tx_push = 1'b0;
		rx_pop = 1'b0;
		if (access)
		begin
			case (paddr)
				`I2S_REG_CMD:
					if (pwrite)
					begin
						cmd.tx_start = pwdata[`I2S_CMD_TX_START];
						cmd.tx_stop = pwdata[`I2S_CMD_TX_STOP];
						cmd.rx_enable = pwdata[`I2S_CMD_RX_ENABLE];
						cmd.rx_disable = pwdata[`I2S_CMD_RX_DISABLE];
						cmd.irq_clear = pwdata[`I2S_CMD_IRQ_CLEAR];
						cmd.flag_clear = pwdata[`I2S_CMD_FLAG_CLEAR];
					end
				`I2S_REG_STATUS:
					prdata = status_word;
				`I2S_REG_TX_DATA:
					if (pwrite)
					begin
						// Full FIFO drops the write
						if (tx_stat.full)
							pslverr = 1'b1;
						else
							tx_push = 1'b1;
					end
				`I2S_REG_RX_DATA:
					// Empty read returns zero
					if (!pwrite && !rx_stat.empty)
					begin
						rx_pop = 1'b1;
						prdata = rx_rdata;
					end
				`I2S_REG_IRQ_LEVEL:
					prdata = `I2S_APB_DATA_W'(irq_level);
				default:
					pslverr = 1'b1;
			endcase
		end
	end

	// Receive interrupt threshold
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			irq_level <= '0;
		else if (access && pwrite && (paddr == `I2S_REG_IRQ_LEVEL))
			irq_level <= pwdata[`I2S_FIFO_LEVEL_W-1:0];
	end

endmodule

// ==== design/i2s_ctrl.sv ====
/*
 * I2S control
 * Transmit state machine choosing a queued frame or silence
 * at every frame boundary, receive enable and push gating,
 * sticky underflow and overflow flags, receive-level interrupt.
 */
`timescale 1ns/100ps

module i2s_ctrl
	import i2s_reg_pkg::*, i2s_audio_pkg::*;
(
	input logic clk,
	input logic rstnn,
	input i2s_cmd_t cmd,
	input level_t irq_level,
	input fifo_stat_t tx_stat,
	input fifo_stat_t rx_stat,
	input frame_t tx_head,
	input logic frame_req,
	input logic rx_valid,
	input frame_t rx_frame,
	output logic tx_pop,
	output logic tx_load,
	output frame_t tx_frame,
	output logic rx_push,
	output frame_t rx_wdata,
	output i2s_status_t status,
	output logic irq
);

	tx_state_t tx_state;
	logic tx_running;
	logic rx_enabled;
	logic tx_underflow;
	logic rx_overflow;

	// **************************************************
	// Transmit state machine
	// **************************************************
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			tx_state <= TX_IDLE;
		else if (cmd.tx_stop)
			tx_state <= TX_IDLE;
		else
			case (tx_state)
				TX_IDLE:
					if (cmd.tx_start)
						tx_state <= TX_PREFILL;
				TX_PREFILL:
					// Wait for at least one queued frame
					if (!tx_stat.empty)
						tx_state <= TX_RUN;
				default:
					tx_state <= TX_RUN;
			endcase
	end

	assign tx_running = (tx_state == TX_RUN);

	// Every frame boundary loads something, silence unless a frame is ready
	assign tx_pop = frame_req & tx_running & ~tx_stat.empty;
	assign tx_load = frame_req;
	assign tx_frame = tx_pop ? tx_head : '0;

	// Receive path
	assign rx_push = rx_valid & rx_enabled & ~rx_stat.full;
	assign rx_wdata = rx_frame;

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			rx_enabled <= 1'b0;
		else if (cmd.rx_disable)
			rx_enabled <= 1'b0;
		else if (cmd.rx_enable)
			rx_enabled <= 1'b1;
	end

	// **************************************************
	// Sticky flags and interrupt
	// **************************************************
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			tx_underflow <= 1'b0;
			rx_overflow <= 1'b0;
		end
		else if (cmd.flag_clear)
		begin
			tx_underflow <= 1'b0;
			rx_overflow <= 1'b0;
		end
		else
		begin
			if (frame_req && tx_running && tx_stat.empty)
				tx_underflow <= 1'b1;
			if (rx_valid && rx_enabled && rx_stat.full)
				rx_overflow <= 1'b1;
		end
	end

	// Held until cleared, even when the level drops again
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			irq <= 1'b0;
		else if (cmd.irq_clear)
			irq <= 1'b0;
		else if (rx_enabled && (rx_stat.level >= irq_level))
			irq <= 1'b1;
	end

	always_comb
	begin
		status.tx_running = tx_running;
		status.rx_enabled = rx_enabled;
		status.irq = irq;
		status.tx_underflow = tx_underflow;
		status.rx_overflow = rx_overflow;
	end

endmodule

// ==== design/i2s_frame_fifo.sv ====
/*
 * I2S frame FIFO
 * Circular buffer with show-ahead read data and a level count.
 */
`timescale 1ns/100ps
`include "i2s_macros.svh"

module i2s_frame_fifo
	import i2s_reg_pkg::*, i2s_audio_pkg::*;
#(
	parameter int DEPTH = `I2S_FIFO_DEPTH
)
(
	input logic clk,
	input logic rstnn,
	input logic push,
	input frame_t wdata,
	input logic pop,
	output frame_t rdata,
	output fifo_stat_t stat
);

	localparam int PTR_W = $clog2(DEPTH);

	frame_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	level_t level;

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// Head of the queue is always on rdata
	assign rdata = mem[rd_ptr];
	assign stat.level = level;
	assign stat.empty = (level == '0);
	assign stat.full = (level == $bits(level_t)'(DEPTH));

endmodule

// ==== design/i2s_serdes.sv ====
/*
 * I2S bit clock, word select and data shifters
 * sclk is clk divided by twice I2S_SCLK_DIV. lrck is low for the
 * left sample. Data runs MSB first, one sclk after each lrck edge,
 * driven on sclk falling edges and sampled on rising edges.
 */
`timescale 1ns/100ps
`include "i2s_macros.svh"

module i2s_serdes
	import i2s_audio_pkg::*;
(
	input logic clk,
	input logic rstnn,
	input logic tx_load,
	input frame_t tx_frame,
	input logic din,
	output logic sclk,
	output logic lrck,
	output logic dout,
	output logic frame_req,
	output logic rx_valid,
	output frame_t rx_frame
);

	localparam int DIV_W = $clog2(`I2S_SCLK_DIV);
	localparam int FRAME_W = $bits(frame_t);
	localparam int BIT_W = $clog2(FRAME_W);

	logic [DIV_W-1:0] div_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic [BIT_W-1:0] bit_cnt_next;
	logic div_end;
	logic sclk_fall;
	logic sclk_rise;
	logic frame_done;
	frame_t tx_shift;
	frame_t rx_shift;

	// **************************************************
	// Bit clock and word select
	// **************************************************
	assign div_end = (div_cnt == DIV_W'(`I2S_SCLK_DIV - 1));
	assign sclk_fall = div_end & sclk;
	assign sclk_rise = div_end & ~sclk;
	assign bit_cnt_next = bit_cnt + 1'b1;

	// Last bit slot of the frame, lrck falls at the end of this cycle
	assign frame_req = sclk_fall & (bit_cnt == '1);
	// First slot done, the right LSB was sampled half a period ago
	assign frame_done = sclk_fall & (bit_cnt == '0);

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			div_cnt <= '0;
			sclk <= 1'b0;
		end
		else if (div_end)
		begin
			div_cnt <= '0;
			sclk <= ~sclk;
		end
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// **************************************************
	// Transmit
	// **************************************************
	// Shifting out the old LSB while the new frame loads
	// gives the one-bit delay after lrck
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			bit_cnt <= '0;
			lrck <= 1'b0;
			dout <= 1'b0;
			tx_shift <= '0;
		end
		else if (sclk_fall)
		begin
			bit_cnt <= bit_cnt_next;
			lrck <= bit_cnt_next[BIT_W-1];
			dout <= tx_shift[FRAME_W-1];
			if (tx_load)
				tx_shift <= tx_frame;
			else
				tx_shift <= {tx_shift[FRAME_W-2:0], 1'b0};
		end
	end

	// **************************************************
	// Receive
	// **************************************************
	always_ff @(posedge clk)
	begin
		if (sclk_rise)
			rx_shift <= {rx_shift[FRAME_W-2:0], din};
		if (frame_done)
			rx_frame <= rx_shift;
	end

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			rx_valid <= 1'b0;
		else
			rx_valid <= frame_done;
	end

endmodule

// ==== design/i2s_master.sv ====
/*
 * I2S audio master
 * APB register block, control, transmit and receive frame
 * FIFOs and the serial interface.
 */
`timescale 1ns/100ps
`include "i2s_macros.svh"

module i2s_master
	import i2s_reg_pkg::*, i2s_audio_pkg::*;
(
	input logic clk,
	input logic rstnn,
	input logic psel,
	input logic penable,
	input logic [`I2S_ADDR_W-1:0] paddr,
	input logic pwrite,
	input logic [`I2S_APB_DATA_W-1:0] pwdata,
	output logic [`I2S_APB_DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic sclk,
	output logic lrck,
	output logic dout,
	input logic din,
	output logic irq
);

	i2s_cmd_t cmd;
	i2s_status_t status;
	level_t irq_level;
	fifo_stat_t tx_stat;
	fifo_stat_t rx_stat;
	logic tx_push;
	logic tx_pop;
	logic rx_push;
	logic rx_pop;
	frame_t tx_wdata;
	frame_t tx_head;
	frame_t rx_wdata;
	frame_t rx_rdata;
	logic frame_req;
	logic tx_load;
	frame_t tx_frame;
	logic rx_valid;
	frame_t rx_frame;

	i2s_apb_regs i2s_apb_regs_inst (.*);

	i2s_ctrl i2s_ctrl_inst (.*);

	// Software to serializer
	i2s_frame_fifo tx_fifo
	(
		.clk(clk),
		.rstnn(rstnn),
		.push(tx_push),
		.wdata(tx_wdata),
		.pop(tx_pop),
		.rdata(tx_head),
		.stat(tx_stat)
	);

	// Deserializer to software
	i2s_frame_fifo rx_fifo
	(
		.clk(clk),
		.rstnn(rstnn),
		.push(rx_push),
		.wdata(rx_wdata),
		.pop(rx_pop),
		.rdata(rx_rdata),
		.stat(rx_stat)
	);

	i2s_serdes i2s_serdes_inst (.*);

endmodule

// ==== tb/tb_clock.sv ====
/*
 * Testbench clock and reset
 * 8 ns clock, reset held low for 8 cycles and released
 * on a falling edge.
 */
`timescale 1ns/100ps

module tb_clock
(
	output logic clk,
	output logic rstnn
);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		rstnn = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rstnn = 1'b1;
	end

endmodule

// ==== tb/i2s_master_checker.sv ====
/*
 * I2S master protocol checker
 * APB response rules, FIFO push and pop legality and the
 * interrupt level right after reset. Bound to the top level.
 */
`timescale 1ns/100ps

module i2s_master_checker
	import i2s_reg_pkg::*;
(
	input logic clk,
	input logic rstnn,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic tx_push,
	input logic tx_pop,
	input logic rx_push,
	input logic rx_pop,
	input fifo_stat_t tx_stat,
	input fifo_stat_t rx_stat,
	input logic irq
);

	int fail_count = 0;

	// **************************************************
	// APB
	// **************************************************
	pready_high: assert property (@(posedge clk) disable iff (!rstnn) pready)
	else
	begin
		fail_count++;
		$error("pready low");
	end

	pslverr_in_access: assert property (@(posedge clk) disable iff (!rstnn)
		pslverr |-> (psel && penable))
	else
	begin
		fail_count++;
		$error("pslverr outside an access cycle");
	end

	// **************************************************
	// FIFO use
	// **************************************************
	tx_no_push_full: assert property (@(posedge clk) disable iff (!rstnn)
		tx_push |-> !tx_stat.full)
	else
	begin
		fail_count++;
		$error("push into full transmit FIFO");
	end

	tx_no_pop_empty: assert property (@(posedge clk) disable iff (!rstnn)
		tx_pop |-> !tx_stat.empty)
	else
	begin
		fail_count++;
		$error("pop of empty transmit FIFO");
	end

	rx_no_push_full: assert property (@(posedge clk) disable iff (!rstnn)
		rx_push |-> !rx_stat.full)
	else
	begin
		fail_count++;
		$error("push into full receive FIFO");
	end

	rx_no_pop_empty: assert property (@(posedge clk) disable iff (!rstnn)
		rx_pop |-> !rx_stat.empty)
	else
	begin
		fail_count++;
		$error("pop of empty receive FIFO");
	end

	// First edge out of reset
	irq_low_after_reset: assert property (@(posedge clk) $rose(rstnn) |-> !irq)
	else
	begin
		fail_count++;
		$error("irq high right after reset");
	end

endmodule

// ==== tb/i2s_master_tb.sv ====
/*
 * I2S master testbench
 * Applies a table of APB steps to the DUT with dout looped back
 * to din: register map, transmit back-pressure, loopback order,
 * underflow, receive interrupt and receive overflow.
 */
`timescale 1ns/100ps
`include "i2s_macros.svh"

module i2s_master_tb
	import i2s_audio_pkg::*;
();

	localparam int CLK_PERIOD_NS = 8;
	// Two sclk half periods per bit and two samples per frame
	localparam int FRAME_CYCLES = 2 * `I2S_SCLK_DIV * 2 * `I2S_SAMPLE_W;
	localparam int NZ_BUDGET_FRAMES = 4;
	localparam int POLL_CYCLES = 8;
	localparam int MARGIN_CYCLES = 4000;

	// STATUS word bit positions from bit 0 upward
	localparam int ST_TX_RUNNING = 0;
	localparam int ST_RX_ENABLED = 1;
	localparam int ST_IRQ = 2;
	localparam int ST_UNDERFLOW = 3;
	localparam int ST_OVERFLOW = 4;
	localparam int ST_TX_LEVEL = 5;
	localparam int ST_RX_LEVEL = 9;

	localparam logic [31:0] ALL = 32'hFFFF_FFFF;
	localparam logic [31:0] M_RUNNING = 32'(1) << ST_TX_RUNNING;
	localparam logic [31:0] M_RX_EN = 32'(1) << ST_RX_ENABLED;
	localparam logic [31:0] M_IRQ = 32'(1) << ST_IRQ;
	localparam logic [31:0] M_UNDERFLOW = 32'(1) << ST_UNDERFLOW;
	localparam logic [31:0] M_OVERFLOW = 32'(1) << ST_OVERFLOW;
	localparam logic [31:0] M_TX_LEVEL = 32'hF << ST_TX_LEVEL;
	localparam logic [31:0] M_RX_LEVEL = 32'hF << ST_RX_LEVEL;

	localparam logic [31:0] C_TX_START = 32'(1) << `I2S_CMD_TX_START;
	localparam logic [31:0] C_TX_STOP = 32'(1) << `I2S_CMD_TX_STOP;
	localparam logic [31:0] C_RX_ENABLE = 32'(1) << `I2S_CMD_RX_ENABLE;
	localparam logic [31:0] C_RX_DISABLE = 32'(1) << `I2S_CMD_RX_DISABLE;
	localparam logic [31:0] C_IRQ_CLEAR = 32'(1) << `I2S_CMD_IRQ_CLEAR;
	localparam logic [31:0] C_FLAG_CLEAR = 32'(1) << `I2S_CMD_FLAG_CLEAR;

	typedef enum logic [2:0]
	{
		OP_WRITE,
		OP_READ,
		OP_WAIT,
		OP_READ_NZ,
		OP_IRQ
	} op_t;

	// data is the write value, the expected value or a frame count
	typedef struct packed
	{
		op_t op;
		logic [`I2S_ADDR_W-1:0] addr;
		logic [31:0] data;
		logic [31:0] mask;
		logic err;
	} step_t;

	logic clk;
	logic rstnn;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`I2S_ADDR_W-1:0] paddr;
	logic [`I2S_APB_DATA_W-1:0] pwdata;
	logic [`I2S_APB_DATA_W-1:0] prdata;
	logic pready;
	logic pslverr;
	logic sclk;
	logic lrck;
	logic dout;
	logic irq;

	step_t steps[$];
	frame_t frames [9];
	logic [31:0] rng_state;
	logic table_ready;
	int budget_frames;
	int watchdog_ns;
	int errors;
	int checks;

	tb_clock clock_gen
	(
		.clk(clk),
		.rstnn(rstnn)
	);

	// din looped back from dout
	i2s_master i2s_master_inst
	(
		.clk(clk),
		.rstnn(rstnn),
		.psel(psel),
		.penable(penable),
		.paddr(paddr),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.sclk(sclk),
		.lrck(lrck),
		.dout(dout),
		.din(dout),
		.irq(irq)
	);

	bind i2s_master i2s_master_checker protocol_checks
	(
		.clk(clk),
		.rstnn(rstnn),
		.psel(psel),
		.penable(penable),
		.pready(pready),
		.pslverr(pslverr),
		.tx_push(tx_push),
		.tx_pop(tx_pop),
		.rx_push(rx_push),
		.rx_pop(rx_pop),
		.tx_stat(tx_stat),
		.rx_stat(rx_stat),
		.irq(irq)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x_in);
		logic [31:0] x;
		x = x_in;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic add_step(
		input op_t op,
		input logic [`I2S_ADDR_W-1:0] addr,
		input logic [31:0] data,
		input logic [31:0] mask,
		input logic err
	);
		step_t s;
		s.op = op;
		s.addr = addr;
		s.data = data;
		s.mask = mask;
		s.err = err;
		steps.push_back(s);
		if (op == OP_WAIT)
			budget_frames += int'(data);
		else if (op == OP_READ_NZ)
			budget_frames += NZ_BUDGET_FRAMES;
	endtask

	// **************************************************
	// Step table
	// **************************************************
	task automatic build_table();
		for (int i = 0; i < 9; i++)
		begin
			rng_state = xorshift32(rng_state);
			frames[i] = (rng_state == '0) ? 32'h1 : rng_state;
		end
		// Register map
		add_step(OP_READ, `I2S_REG_STATUS, 32'h0, ALL, 1'b0);
		add_step(OP_WRITE, `I2S_REG_IRQ_LEVEL, 32'd9, 32'h0, 1'b0);
		add_step(OP_READ, `I2S_REG_IRQ_LEVEL, 32'd9, ALL, 1'b0);
		add_step(OP_READ, 8'h14, 32'h0, 32'h0, 1'b1);
		add_step(OP_WRITE, 8'h20, 32'h1, 32'h0, 1'b1);
		// Ninth write into a full transmit FIFO is refused
		for (int i = 0; i < 8; i++)
			add_step(OP_WRITE, `I2S_REG_TX_DATA, frames[i], 32'h0, 1'b0);
		add_step(OP_WRITE, `I2S_REG_TX_DATA, frames[8], 32'h0, 1'b1);
		add_step(OP_READ, `I2S_REG_STATUS, 32'(8) << ST_TX_LEVEL, M_TX_LEVEL | M_RUNNING, 1'b0);
		// Loopback with zero frames skipped
		add_step(OP_WRITE, `I2S_REG_CMD, C_RX_ENABLE, 32'h0, 1'b0);
		add_step(OP_WRITE, `I2S_REG_CMD, C_TX_START, 32'h0, 1'b0);
		for (int i = 0; i < 8; i++)
			add_step(OP_READ_NZ, `I2S_REG_RX_DATA, frames[i], ALL, 1'b0);
		// Underflow
		add_step(OP_WAIT, 8'h0, 32'd2, 32'h0, 1'b0);
		add_step(OP_READ, `I2S_REG_STATUS, M_UNDERFLOW | M_RUNNING,
			M_UNDERFLOW | M_RUNNING, 1'b0);
		for (int i = 0; i < 4; i++)
			add_step(OP_READ, `I2S_REG_RX_DATA, 32'h0, ALL, 1'b0);
		add_step(OP_WRITE, `I2S_REG_CMD, C_TX_STOP, 32'h0, 1'b0);
		add_step(OP_WRITE, `I2S_REG_CMD, C_FLAG_CLEAR, 32'h0, 1'b0);
		add_step(OP_READ, `I2S_REG_STATUS, 32'h0, M_UNDERFLOW | M_RUNNING, 1'b0);
		// Interrupt
		add_step(OP_WRITE, `I2S_REG_CMD, C_RX_DISABLE, 32'h0, 1'b0);
		for (int i = 0; i < 8; i++)
			add_step(OP_READ, `I2S_REG_RX_DATA, 32'h0, ALL, 1'b0);
		add_step(OP_READ, `I2S_REG_STATUS, 32'h0, M_RX_LEVEL, 1'b0);
		add_step(OP_WRITE, `I2S_REG_IRQ_LEVEL, 32'd3, 32'h0, 1'b0);
		add_step(OP_WRITE, `I2S_REG_CMD, C_IRQ_CLEAR, 32'h0, 1'b0);
		add_step(OP_IRQ, 8'h0, 32'h0, 32'h0, 1'b0);
		add_step(OP_WRITE, `I2S_REG_CMD, C_RX_ENABLE, 32'h0, 1'b0);
		add_step(OP_WAIT, 8'h0, 32'd1, 32'h0, 1'b0);
		add_step(OP_IRQ, 8'h0, 32'h0, 32'h0, 1'b0);
		add_step(OP_WAIT, 8'h0, 32'd3, 32'h0, 1'b0);
		add_step(OP_IRQ, 8'h0, 32'h1, 32'h0, 1'b0);
		add_step(OP_READ, `I2S_REG_STATUS, M_IRQ | M_RX_EN, M_IRQ | M_RX_EN, 1'b0);
		for (int i = 0; i < 8; i++)
			add_step(OP_READ, `I2S_REG_RX_DATA, 32'h0, ALL, 1'b0);
		add_step(OP_IRQ, 8'h0, 32'h1, 32'h0, 1'b0);
		// Level above threshold with receive disabled keeps irq low
		add_step(OP_WAIT, 8'h0, 32'd4, 32'h0, 1'b0);
		add_step(OP_WRITE, `I2S_REG_CMD, C_RX_DISABLE, 32'h0, 1'b0);
		add_step(OP_WRITE, `I2S_REG_CMD, C_IRQ_CLEAR, 32'h0, 1'b0);
		add_step(OP_IRQ, 8'h0, 32'h0, 32'h0, 1'b0);
		add_step(OP_WAIT, 8'h0, 32'd2, 32'h0, 1'b0);
		add_step(OP_IRQ, 8'h0, 32'h0, 32'h0, 1'b0);
		add_step(OP_READ, `I2S_REG_STATUS, 32'h0, M_IRQ | M_RX_EN, 1'b0);
		// Receive overflow
		add_step(OP_WRITE, `I2S_REG_CMD, C_RX_ENABLE, 32'h0, 1'b0);
		add_step(OP_WAIT, 8'h0, 32'd10, 32'h0, 1'b0);
		add_step(OP_READ, `I2S_REG_STATUS, M_OVERFLOW | (32'(8) << ST_RX_LEVEL),
			M_OVERFLOW | M_RX_LEVEL, 1'b0);
		add_step(OP_WRITE, `I2S_REG_CMD, C_FLAG_CLEAR | C_RX_DISABLE, 32'h0, 1'b0);
		add_step(OP_READ, `I2S_REG_STATUS, 32'h0, M_OVERFLOW | M_RX_EN, 1'b0);
	endtask

	// One APB transfer with the response sampled inside the access cycle
	task automatic bus_access(
		input logic write,
		input logic [`I2S_ADDR_W-1:0] addr,
		input logic [31:0] wdata,
		output logic [31:0] rdata,
		output logic err
	);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#(CLK_PERIOD_NS / 4);
		rdata = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic run_step(input int idx, input step_t step);
		logic [31:0] rdata;
		logic err;
		int waited;
		logic found;
		case (step.op)
			OP_WRITE, OP_READ:
			begin
				bus_access(step.op == OP_WRITE, step.addr, step.data, rdata, err);
				checks++;
				if (err !== step.err)
				begin
					errors++;
					$display("FAIL %0t: step %0d addr %h pslverr %b expected %b",
						$time, idx, step.addr, err, step.err);
				end
				if (step.op == OP_READ && (rdata & step.mask) !== (step.data & step.mask))
				begin
					errors++;
					$display("FAIL %0t: step %0d addr %h read %h expected %h mask %h",
						$time, idx, step.addr, rdata, step.data, step.mask);
				end
			end
			OP_WAIT:
				repeat (step.data * FRAME_CYCLES) @(negedge clk);
			OP_READ_NZ:
			begin
				waited = 0;
				found = 1'b0;
				while (!found && waited < NZ_BUDGET_FRAMES * FRAME_CYCLES)
				begin
					bus_access(1'b0, step.addr, 32'h0, rdata, err);
					if (rdata !== 32'h0)
						found = 1'b1;
					else
					begin
						repeat (POLL_CYCLES) @(negedge clk);
						waited += POLL_CYCLES + 3;
					end
				end
				checks++;
				if (!found)
				begin
					errors++;
					$display("Step %0d: no nonzero frame arrived on RX_DATA in time", idx);
				end
				else if (rdata !== step.data)
				begin
					errors++;
					$display("FAIL %0t: step %0d received frame %h expected %h",
						$time, idx, rdata, step.data);
				end
			end
			default:
			begin
				@(negedge clk);
				checks++;
				if (irq !== step.data[0])
				begin
					errors++;
					$display("FAIL %0t: step %0d irq %b expected %b",
						$time, idx, irq, step.data[0]);
				end
			end
		endcase
	endtask

	// **************************************************
	// Bit clock and word select
	// **************************************************
	// sclk toggles every I2S_SCLK_DIV clocks and lrck toggles every
	// half frame together with a falling sclk
	initial
	begin
		int sclk_cycles;
		int lrck_cycles;
		logic sclk_seen;
		logic lrck_seen;
		logic sclk_last;
		logic lrck_last;
		wait (rstnn === 1'b1);
		@(negedge clk);
		sclk_cycles = 0;
		lrck_cycles = 0;
		sclk_seen = 1'b0;
		lrck_seen = 1'b0;
		sclk_last = sclk;
		lrck_last = lrck;
		forever
		begin
			@(negedge clk);
			sclk_cycles++;
			lrck_cycles++;
			if (sclk !== sclk_last)
			begin
				if (sclk_seen)
				begin
					checks++;
					if (sclk_cycles != `I2S_SCLK_DIV)
					begin
						errors++;
						$display("FAIL %0t: sclk half period %0d clk cycles expected %0d",
							$time, sclk_cycles, `I2S_SCLK_DIV);
					end
				end
				sclk_seen = 1'b1;
				sclk_cycles = 0;
			end
			if (lrck !== lrck_last)
			begin
				checks++;
				if (sclk_last !== 1'b1 || sclk !== 1'b0)
				begin
					errors++;
					$display("FAIL %0t: lrck changed away from a falling sclk edge", $time);
				end
				if (lrck_seen)
				begin
					checks++;
					if (lrck_cycles != FRAME_CYCLES / 2)
					begin
						errors++;
						$display("FAIL %0t: lrck half period %0d clk cycles expected %0d",
							$time, lrck_cycles, FRAME_CYCLES / 2);
					end
				end
				lrck_seen = 1'b1;
				lrck_cycles = 0;
			end
			sclk_last = sclk;
			lrck_last = lrck;
		end
	end

	// **************************************************
	// Main sequence
	// **************************************************
	initial
	begin
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		errors = 0;
		checks = 0;
		budget_frames = 0;
		rng_state = 32'd19262;
		build_table();
		watchdog_ns = (budget_frames * FRAME_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;
		table_ready = 1'b1;
		wait (rstnn === 1'b1);
		@(negedge clk);
		foreach (steps[i])
			run_step(i, steps[i]);
		errors += i2s_master_inst.protocol_checks.fail_count;
		$display("checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, i2s_master_inst.protocol_checks.fail_count);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Limit from the frames the table waits plus APB overhead
	initial
	begin
		wait (table_ready === 1'b1);
		#(watchdog_ns);
		$display("Watchdog expired at %0t before the step table finished", $time);
		$display("tests failed");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+design
design/i2s_reg_pkg.sv
design/i2s_audio_pkg.sv
design/i2s_apb_regs.sv
design/i2s_ctrl.sv
design/i2s_frame_fifo.sv
design/i2s_serdes.sv
design/i2s_master.sv
tb/tb_clock.sv
tb/i2s_master_checker.sv
tb/i2s_master_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS = --lint-only --timing --timescale 1ns/100ps
TOP = i2s_master_tb
RTL_TOP = i2s_master
FILELIST = all.f
OBJ_DIR = obj_dir
LOG = sim.log
RUN_ARGS = +verilator+error+limit+100

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) design/*.sv design/*.svh tb/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "tests failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
